/* fir.f */
+incdir+logic
logic/fir_pkg.sv
logic/fir_regs.sv
logic/fir_tap_store.sv
logic/fir_sample_ring.sv
logic/fir_mac.sv
logic/fir_top.sv
sim/fir_clk_gen.sv
sim/fir_chk.sv
sim/fir_monitor.sv
sim/fir_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fir_tb -f fir.f \
    && ./obj_dir/Vfir_tb > sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

/* sim/fir_tb.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_tb;

    localparam int LEN_A  = 40;
    localparam int TAPS_A = 11;
    localparam int LEN_B  = 24;
    localparam int TAPS_B = 5;
    // two runs of setup A, one of setup B, plus register traffic
    localparam int CYCLE_LIMIT = 2 * LEN_A * (TAPS_A + 8) + LEN_B * (TAPS_B + 8) + 500;

    logic                   axis_clk;
    logic                   axis_rst_n;
    logic                   awvalid;
    logic [`FIR_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [`FIR_DATA_W-1:0] wdata;
    logic                   arvalid;
    logic [`FIR_ADDR_W-1:0] araddr;
    logic                   rready;
    logic                   ss_tvalid;
    logic [`FIR_DATA_W-1:0] ss_tdata;
    logic                   sm_tready;
    logic                   awready;
    logic                   wready;
    logic                   arready;
    logic                   rvalid;
    logic [`FIR_DATA_W-1:0] rdata;
    logic                   ss_tready;
    logic                   sm_tvalid;
    logic [`FIR_DATA_W-1:0] sm_tdata;
    logic                   sm_tlast;
    logic [`FIR_DATA_W-1:0] exp_rdata;
    logic [`FIR_DATA_W-1:0] exp_data;
    logic                   exp_last;
    logic                   test_end;
    logic [2:0]             test_id;
    logic                   sm_bp;          // random stalls on the result stream
    int                     checks;
    int                     errors;
    int                     results;
    int                     cycles;
    int                     tap_num_model;
    integer                 seed = 32'hb8a031b0;
    logic [`FIR_DATA_W-1:0] h_model [`FIR_MAX_TAPS];
    logic [`FIR_DATA_W-1:0] x_model [$];    // samples since start

    fir_clk_gen clk0 (.axis_clk(axis_clk), .axis_rst_n(axis_rst_n));

    fir_top dut0 (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awready(awready), .wready(wready), .awvalid(awvalid), .awaddr(awaddr),
        .wvalid(wvalid), .wdata(wdata), .arready(arready), .rready(rready),
        .arvalid(arvalid), .araddr(araddr), .rvalid(rvalid), .rdata(rdata),
        .ss_tvalid(ss_tvalid), .ss_tdata(ss_tdata), .ss_tready(ss_tready),
        .sm_tready(sm_tready), .sm_tvalid(sm_tvalid), .sm_tdata(sm_tdata),
        .sm_tlast(sm_tlast)
    );

    fir_monitor mon0 (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .exp_rdata(exp_rdata),
        .sm_tvalid(sm_tvalid), .sm_tready(sm_tready), .sm_tdata(sm_tdata),
        .sm_tlast(sm_tlast), .exp_data(exp_data), .exp_last(exp_last),
        .test_end(test_end), .test_id(test_id),
        .checks(checks), .errors(errors), .results(results)
    );

    bind fir_top fir_chk chk0 (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .sm_tvalid(sm_tvalid), .sm_tready(sm_tready), .sm_tdata(sm_tdata),
        .rvalid(rvalid), .rready(rready), .ss_tready(ss_tready)
    );

    function automatic logic [`FIR_ADDR_W-1:0] tap_addr(input int k);
        return `FIR_TAP_BASE + 12'(4 * k);
    endfunction

    // y[n] = sum of h[k] * x[n-k], older samples count as zero
    function automatic logic [`FIR_DATA_W-1:0] filter_output();
        logic [`FIR_DATA_W-1:0] acc;
        int                     n;
        acc = '0;
        n   = x_model.size() - 1;
        for (int k = 0; k < tap_num_model; k++) begin
            if (n - k >= 0) begin
                acc = acc + h_model[k] * x_model[n - k];
            end
        end
        return acc;
    endfunction

    task automatic write_reg(input logic [`FIR_ADDR_W-1:0] addr,
                             input logic [`FIR_DATA_W-1:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) @(negedge axis_clk);
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge axis_clk);                // commit edge has passed
    endtask

    task automatic read_expect(input logic [`FIR_ADDR_W-1:0] addr,
                               input logic [`FIR_DATA_W-1:0] value);
        araddr    = addr;
        exp_rdata = value;
        arvalid   = 1'b1;
        while (!arready) @(negedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge axis_clk);
        @(negedge axis_clk);                // rvalid held one cycle without rready
        rready = 1'b1;
        @(negedge axis_clk);                // monitor compares on this edge
        rready = 1'b0;
    endtask

    task automatic configure(input int len, input int taps);
        write_reg(`FIR_REG_LEN, 32'(len));
        write_reg(`FIR_REG_TAPS, 32'(taps));
        tap_num_model = taps;
        for (int k = 0; k < taps; k++) begin
            h_model[k] = $random(seed);
            write_reg(tap_addr(k), h_model[k]);
        end
    endtask

    task automatic run_filter(input int len);
        int                     base;
        logic [`FIR_DATA_W-1:0] v;
        base = results;
        x_model.delete();
        write_reg(`FIR_REG_AP, 32'h1);
        for (int n = 0; n < len; n++) begin
            v         = $random(seed);
            ss_tdata  = v;
            ss_tvalid = 1'b1;
            while (!ss_tready) @(negedge axis_clk);
            x_model.push_back(v);           // taken on the next rising edge
            exp_data = filter_output();
            exp_last = (n == len - 1);
            @(negedge axis_clk);
            ss_tvalid = 1'b0;
        end
        while (results < base + len) @(negedge axis_clk);
    endtask

    // runs alongside a filter run
    task automatic busy_probe();
        while (!sm_tvalid) @(negedge axis_clk);    // first result pending
        read_expect(tap_addr(0), `FIR_BUSY_READ);
        write_reg(tap_addr(2), ~h_model[2]);
        read_expect(tap_addr(2), `FIR_BUSY_READ);
        write_reg(`FIR_REG_LEN, 32'd7);
        read_expect(`FIR_REG_LEN, 32'(LEN_A));
    endtask

    task automatic end_test(input logic [2:0] id);
        test_id  = id;
        test_end = 1'b1;
        @(negedge axis_clk);
        test_end = 1'b0;
    endtask

    initial begin
        sm_tready = 1'b0;
        forever begin
            @(negedge axis_clk);
            sm_tready = !sm_bp || (($random(seed) & 3) != 0);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge axis_clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_bp     = 1'b0;
        exp_rdata = '0;
        exp_data  = '0;
        exp_last  = 1'b0;
        test_end  = 1'b0;
        test_id   = '0;
        tap_num_model = 0;
        @(posedge axis_rst_n);
        @(negedge axis_clk);

        read_expect(`FIR_REG_AP, 32'h4);    // idle after reset
        configure(LEN_A, TAPS_A);
        read_expect(`FIR_REG_LEN, 32'(LEN_A));
        read_expect(`FIR_REG_TAPS, 32'(TAPS_A));
        for (int k = 0; k < TAPS_A; k++) begin
            read_expect(tap_addr(k), h_model[k]);
        end
        end_test(3'd1);

        run_filter(LEN_A);
        end_test(3'd2);

        read_expect(`FIR_REG_AP, 32'h2);    // done, not idle
        read_expect(`FIR_REG_AP, 32'h4);
        end_test(3'd4);

        sm_bp = 1'b1;
        fork
            run_filter(LEN_A);
            busy_probe();
        join
        sm_bp = 1'b0;
        end_test(3'd3);

        read_expect(`FIR_REG_AP, 32'h2);
        read_expect(`FIR_REG_AP, 32'h4);
        read_expect(`FIR_REG_LEN, 32'(LEN_A));
        for (int k = 0; k < TAPS_A; k++) begin
            read_expect(tap_addr(k), h_model[k]);
        end
        end_test(3'd5);

        configure(LEN_B, TAPS_B);
        run_filter(LEN_B);
        read_expect(`FIR_REG_AP, 32'h2);
        read_expect(`FIR_REG_AP, 32'h4);
        end_test(3'd6);

        $display("%0d checks, %0d results, %0d errors", checks, results, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sim/fir_monitor.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_monitor (
    input  logic                   axis_clk,
    input  logic                   axis_rst_n,
    input  logic                   rvalid,
    input  logic                   rready,
    input  logic [`FIR_DATA_W-1:0] rdata,
    input  logic [`FIR_DATA_W-1:0] exp_rdata,
    input  logic                   sm_tvalid,
    input  logic                   sm_tready,
    input  logic [`FIR_DATA_W-1:0] sm_tdata,
    input  logic                   sm_tlast,
    input  logic [`FIR_DATA_W-1:0] exp_data,
    input  logic                   exp_last,
    input  logic                   test_end,
    input  logic [2:0]             test_id,
    output int                     checks,
    output int                     errors,
    output int                     results
);

    int test_checks;
    int test_errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "register readback";
            3'd2:    return "filter output";
            3'd3:    return "back-pressure";
            3'd4:    return "completion protocol";
            3'd5:    return "busy protection";
            3'd6:    return "second run";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input string name, input logic [`FIR_DATA_W-1:0] got,
                           input logic [`FIR_DATA_W-1:0] want);
        checks++;
        test_checks++;
        if (got !== want) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
            errors++;
            test_errors++;
        end
    endtask

    // handshakes sampled on the rising edge, inputs settle at the falling one
    always @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            checks      = 0;
            errors      = 0;
            results     = 0;
            test_checks = 0;
            test_errors = 0;
        end else begin
            if (rvalid && rready) begin
                compare("rdata", rdata, exp_rdata);
            end
            if (sm_tvalid && sm_tready) begin
                compare("sm_tdata", sm_tdata, exp_data);
                compare("sm_tlast", {31'b0, sm_tlast}, {31'b0, exp_last});
                results++;
            end
            if (test_end) begin
                $display("test %0d %-20s %0d checks, %0d errors: %s", test_id,
                         test_name(test_id), test_checks, test_errors,
                         (test_errors == 0) ? "ok" : "FAIL");
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

/* sim/fir_chk.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_chk (
    input logic                   axis_clk,
    input logic                   axis_rst_n,
    input logic                   sm_tvalid,
    input logic                   sm_tready,
    input logic [`FIR_DATA_W-1:0] sm_tdata,
    input logic                   rvalid,
    input logic                   rready,
    input logic                   ss_tready
);

    // stalled result must not move
    sm_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata))
        else $error("sm_tdata or sm_tvalid changed while sm_tready was low");

    rd_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // one sample in flight
    one_in_flight: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid |-> !ss_tready)
        else $error("ss_tready high while a result is pending");

endmodule

/* sim/fir_clk_gen.sv */
`timescale 1ns/1ns

module fir_clk_gen (
    output logic axis_clk,
    output logic axis_rst_n
);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;    // 10 ns period
    end

    initial begin
        axis_rst_n = 1'b0;
        repeat (2) @(posedge axis_clk);
        @(negedge axis_clk);                // release away from the active edge
        axis_rst_n = 1'b1;
    end

endmodule

/* logic/fir_top.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_top (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    output logic                    awready,
    output logic                    wready,
    input  logic                    awvalid,
    input  logic [`FIR_ADDR_W-1:0]  awaddr,
    input  logic                    wvalid,
    input  logic [`FIR_DATA_W-1:0]  wdata,
    output logic                    arready,
    input  logic                    rready,
    input  logic                    arvalid,
    input  logic [`FIR_ADDR_W-1:0]  araddr,
    output logic                    rvalid,
    output logic [`FIR_DATA_W-1:0]  rdata,
    input  logic                    ss_tvalid,
    input  logic [`FIR_DATA_W-1:0]  ss_tdata,
    output logic                    ss_tready,
    input  logic                    sm_tready,
    output logic                    sm_tvalid,
    output logic [`FIR_DATA_W-1:0]  sm_tdata,
    output logic                    sm_tlast
);

    fir_pkg::axil_wr_t      wr;
    fir_pkg::axil_rd_req_t  rd_req;
    fir_pkg::tap_wr_t       tap_wr;
    fir_pkg::run_cfg_t      cfg;
    logic [`FIR_IDX_W-1:0]  tap_rd_idx;
    logic [`FIR_IDX_W-1:0]  mac_idx;    // tap index and sample age
    logic [`FIR_DATA_W-1:0] tap_rd_data;
    logic [`FIR_DATA_W-1:0] h;
    logic [`FIR_DATA_W-1:0] x;
    logic                   start;
    logic                   run_done;
    logic                   new_sample;
    logic                   sample_used;

    assign wr     = '{awvalid: awvalid, awaddr: awaddr, wvalid: wvalid, wdata: wdata};
    assign rd_req = '{arvalid: arvalid, araddr: araddr, rready: rready};

    fir_regs u_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .wr          (wr),
        .rd_req      (rd_req),
        .awready     (awready),
        .wready      (wready),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .tap_wr      (tap_wr),
        .tap_rd_idx  (tap_rd_idx),
        .tap_rd_data (tap_rd_data),
        .cfg         (cfg),
        .start       (start),
        .run_done    (run_done)
    );

    fir_tap_store u_taps (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .tap_wr      (tap_wr),
        .cfg_rd_idx  (tap_rd_idx),
        .cfg_rd_data (tap_rd_data),
        .mac_idx     (mac_idx),
        .h           (h)
    );

    fir_sample_ring u_ring (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start       (start),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tready   (ss_tready),
        .new_sample  (new_sample),
        .age         (mac_idx),
        .sample_used (sample_used),
        .x           (x)
    );

    fir_mac u_mac (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .cfg         (cfg),
        .start       (start),
        .new_sample  (new_sample),
        .idx         (mac_idx),
        .x           (x),
        .h           (h),
        .sample_used (sample_used),
        .sm_tvalid   (sm_tvalid),
        .sm_tready   (sm_tready),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .run_done    (run_done)
    );

endmodule

/* logic/fir_mac.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_mac (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  fir_pkg::run_cfg_t       cfg,
    input  logic                    start,
    input  logic                    new_sample,
    output logic [`FIR_IDX_W-1:0]   idx,
    input  logic [`FIR_DATA_W-1:0]  x,
    input  logic [`FIR_DATA_W-1:0]  h,
    output logic                    sample_used,
    output logic                    sm_tvalid,
    input  logic                    sm_tready,
    output logic [`FIR_DATA_W-1:0]  sm_tdata,
    output logic                    sm_tlast,
    output logic                    run_done
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ISSUE = 2'd1;
    localparam logic [1:0] S_WAIT  = 2'd2;

    logic [1:0]             state;
    logic                   issue;      // idx is a live read this cycle
    logic                   is_last;
    logic                   rd_vld;
    logic                   rd_first;
    logic                   rd_last;
    logic                   p_vld;
    logic                   p_first;
    logic                   p_last;
    logic [`FIR_DATA_W-1:0] prod;
    logic [`FIR_DATA_W-1:0] acc;
    logic [`FIR_DATA_W-1:0] sum;
    logic [`FIR_DATA_W-1:0] out_cnt;
    logic                   sm_hs;

    assign issue       = (state == S_ISSUE) || (state == S_IDLE && new_sample);
    assign is_last     = ({1'b0, idx} + 1'b1) >= cfg.tap_num;
    assign sum         = p_first ? prod : acc + prod;    // first product clears the sum
    assign sm_hs       = sm_tvalid && sm_tready;
    assign sample_used = sm_hs;
    assign run_done    = sm_hs && sm_tlast;
    assign sm_tdata    = acc;                            // holds while waiting for sm_tready

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= S_IDLE;
            idx       <= '0;
            rd_vld    <= 1'b0;
            rd_first  <= 1'b0;
            rd_last   <= 1'b0;
            p_vld     <= 1'b0;
            p_first   <= 1'b0;
            p_last    <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            out_cnt   <= '0;
        end else if (start) begin
            state     <= S_IDLE;
            idx       <= '0;
            rd_vld    <= 1'b0;
            p_vld     <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
            out_cnt   <= '0;
        end else begin
            case (state)
                S_IDLE, S_ISSUE: begin
                    if (issue && is_last) begin
                        idx   <= '0;
                        state <= S_WAIT;
                    end else if (issue) begin
                        idx   <= idx + 1'b1;
                        state <= S_ISSUE;
                    end
                end
                S_WAIT:  if (sm_hs) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
            // x and h return one cycle after idx
            rd_vld   <= issue;
            rd_first <= issue && (idx == '0);
            rd_last  <= issue && is_last;
            p_vld    <= rd_vld;
            p_first  <= rd_first;
            p_last   <= rd_last;
            if (p_vld && p_last) begin
                sm_tvalid <= 1'b1;
                sm_tlast  <= (out_cnt + 32'd1) == cfg.data_length;
            end else if (sm_hs) begin
                sm_tvalid <= 1'b0;
                sm_tlast  <= 1'b0;
                out_cnt   <= out_cnt + 32'd1;
            end
        end
    end

    // 32 bit product and sum wrap
    always_ff @(posedge axis_clk) begin
        if (rd_vld) begin
            prod <= x * h;
        end
        if (p_vld) begin
            acc <= sum;
        end
    end

endmodule

/* logic/fir_sample_ring.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_sample_ring (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    start,
    input  logic                    ss_tvalid,
    input  logic [`FIR_DATA_W-1:0]  ss_tdata,
    output logic                    ss_tready,
    output logic                    new_sample,
    input  logic [`FIR_IDX_W-1:0]   age,
    input  logic                    sample_used,
    output logic [`FIR_DATA_W-1:0]  x
);

    logic [`FIR_DATA_W-1:0] hist [`FIR_MAX_TAPS];
    logic [`FIR_IDX_W-1:0]  wr_ptr;     // slot of newest sample
    logic [`FIR_IDX_W-1:0]  nxt_ptr;
    logic [`FIR_IDX_W-1:0]  rd_slot;
    logic [`FIR_IDX_W:0]    count;      // valid history since start
    logic                   armed;
    logic                   take;

    assign ss_tready = armed && !new_sample && !start;    // start edge clears the ring
    assign take      = ss_tvalid && ss_tready;
    assign nxt_ptr   = wr_ptr + 1'b1;
    assign rd_slot   = wr_ptr - age;    // wraps around the ring

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr     <= '1;
            count      <= '0;
            armed      <= 1'b0;
            new_sample <= 1'b0;
        end else if (start) begin
            wr_ptr     <= '1;           // first sample lands in slot 0
            count      <= '0;
            armed      <= 1'b1;
            new_sample <= 1'b0;
        end else if (take) begin
            wr_ptr     <= nxt_ptr;
            new_sample <= 1'b1;
            if (count != `FIR_MAX_TAPS) begin
                count <= count + 1'b1;
            end
        end else if (sample_used) begin
            new_sample <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (take) begin
            hist[nxt_ptr] <= ss_tdata;
        end
        // older than the run reads as zero
        x <= ({1'b0, age} < count) ? hist[rd_slot] : '0;
    end

endmodule

/* logic/fir_tap_store.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_tap_store (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  fir_pkg::tap_wr_t        tap_wr,
    input  logic [`FIR_IDX_W-1:0]   cfg_rd_idx,
    output logic [`FIR_DATA_W-1:0]  cfg_rd_data,
    input  logic [`FIR_IDX_W-1:0]   mac_idx,
    output logic [`FIR_DATA_W-1:0]  h
);

    logic [`FIR_DATA_W-1:0] taps [`FIR_MAX_TAPS];

    always_ff @(posedge axis_clk) begin
        if (tap_wr.en) begin
            taps[tap_wr.idx] <= tap_wr.data;
        end
    end

    assign cfg_rd_data = taps[cfg_rd_idx];     // register port readback

    // MAC port, one cycle latency
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            h <= '0;
        end else begin
            h <= taps[mac_idx];
        end
    end

endmodule

/* logic/fir_regs.sv */
`timescale 1ns/1ns
`include "fir_consts.svh"

module fir_regs (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  fir_pkg::axil_wr_t       wr,
    input  fir_pkg::axil_rd_req_t   rd_req,
    output logic                    awready,
    output logic                    wready,
    output logic                    arready,
    output logic                    rvalid,
    output logic [`FIR_DATA_W-1:0]  rdata,
    output fir_pkg::tap_wr_t        tap_wr,
    output logic [`FIR_IDX_W-1:0]   tap_rd_idx,
    input  logic [`FIR_DATA_W-1:0]  tap_rd_data,
    output fir_pkg::run_cfg_t       cfg,
    output logic                    start,
    input  logic                    run_done
);

    logic                   aw_v;       // write address held
    logic [`FIR_ADDR_W-1:0] aw_addr;
    logic                   w_v;        // write data held
    logic [`FIR_DATA_W-1:0] w_data;
    logic                   commit;
    logic [`FIR_ADDR_W-1:0] wr_off;
    logic [`FIR_ADDR_W-1:0] rd_off;
    logic                   wr_is_tap;
    logic                   rd_is_tap;
    logic                   rd_hs;
    logic [`FIR_DATA_W-1:0] rd_mux;
    fir_pkg::ap_state_t     ap;

    assign commit    = aw_v && w_v;
    assign wr_off    = aw_addr - `FIR_TAP_BASE;
    assign rd_off    = rd_req.araddr - `FIR_TAP_BASE;
    assign wr_is_tap = wr_off < (`FIR_MAX_TAPS * 4);     // below base wraps high
    assign rd_is_tap = rd_off < (`FIR_MAX_TAPS * 4);
    assign rd_hs     = arready && rd_req.arvalid;
    assign start     = ap.start;

    assign tap_wr.en   = commit && ap.idle && wr_is_tap;
    assign tap_wr.idx  = wr_off[`FIR_IDX_W+1:2];
    assign tap_wr.data = w_data;
    assign tap_rd_idx  = rd_off[`FIR_IDX_W+1:2];

    always_comb begin
        rd_mux = '0;
        if (rd_is_tap) begin
            rd_mux = ap.idle ? tap_rd_data : `FIR_BUSY_READ;
        end else begin
            case (rd_req.araddr)
                `FIR_REG_AP:   rd_mux = {{(`FIR_DATA_W-3){1'b0}}, ap};
                `FIR_REG_LEN:  rd_mux = cfg.data_length;
                `FIR_REG_TAPS: rd_mux = {{(`FIR_DATA_W-`FIR_IDX_W-1){1'b0}}, cfg.tap_num};
                default:       rd_mux = '0;
            endcase
        end
    end

    // write and read channel handshakes
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            aw_v    <= 1'b0;
            w_v     <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= wr.awvalid && !aw_v && !awready;     // one cycle pulse
            wready  <= wr.wvalid && !w_v && !wready;
            if (awready && wr.awvalid) begin
                aw_v <= 1'b1;
            end else if (commit) begin
                aw_v <= 1'b0;
            end
            if (wready && wr.wvalid) begin
                w_v <= 1'b1;
            end else if (commit) begin
                w_v <= 1'b0;
            end
            arready <= rd_req.arvalid && !arready && !rvalid && !aw_v && !w_v;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rvalid && rd_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (awready && wr.awvalid) begin
            aw_addr <= wr.awaddr;
        end
        if (wready && wr.wvalid) begin
            w_data <= wr.wdata;
        end
        if (rd_hs) begin
            rdata <= rd_mux;
        end
    end

    // ap word and run configuration
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap  <= '{idle: 1'b1, done: 1'b0, start: 1'b0};
            cfg <= '0;
        end else begin
            if (ap.start) begin
                ap.start <= 1'b0;                           // start lasts one cycle
            end
            if (run_done) begin
                ap.done <= 1'b1;
                ap.idle <= 1'b0;
            end else if (rd_hs && rd_req.araddr == `FIR_REG_AP && ap.done) begin
                ap.done <= 1'b0;                            // done seen by host
                ap.idle <= 1'b1;
            end else if (commit && ap.idle) begin
                case (aw_addr)
                    `FIR_REG_AP: begin
                        if (w_data[0]) begin
                            ap.start <= 1'b1;
                            ap.idle  <= 1'b0;
                        end
                    end
                    `FIR_REG_LEN:  cfg.data_length <= w_data;
                    `FIR_REG_TAPS: cfg.tap_num <= w_data[`FIR_IDX_W:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

/* logic/fir_pkg.sv */
`include "fir_consts.svh"

package fir_pkg;

    typedef struct packed {
        logic                   awvalid;
        logic [`FIR_ADDR_W-1:0] awaddr;
        logic                   wvalid;
        logic [`FIR_DATA_W-1:0] wdata;
    } axil_wr_t;

    typedef struct packed {
        logic                   arvalid;
        logic [`FIR_ADDR_W-1:0] araddr;
        logic                   rready;
    } axil_rd_req_t;

    // one coefficient write
    typedef struct packed {
        logic                   en;
        logic [`FIR_IDX_W-1:0]  idx;
        logic [`FIR_DATA_W-1:0] data;
    } tap_wr_t;

    typedef struct packed {
        logic [`FIR_DATA_W-1:0] data_length;
        logic [`FIR_IDX_W:0]    tap_num;     // 1..32, needs one extra bit
    } run_cfg_t;

    // field order matches bits 2..0 of the ap word
    typedef struct packed {
        logic idle;
        logic done;
        logic start;
    } ap_state_t;

endpackage

/* logic/fir_consts.svh */
`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// widths
`define FIR_DATA_W      32
`define FIR_ADDR_W      12
`define FIR_IDX_W       5

// tap store and sample ring depth
`define FIR_MAX_TAPS    32

// register map
`define FIR_REG_AP      12'h000
`define FIR_REG_LEN     12'h010
`define FIR_REG_TAPS    12'h014
`define FIR_TAP_BASE    12'h080

// tap readback while a run is active
`define FIR_BUSY_READ   32'hffff_ffff

`endif
